//--- source/nmr_pkg.sv
// shared widths, register map and command format of the nmr pulse sequencer
// every block imports what it needs from here
package nmr_pkg;

	// ================================================
	// bus and field widths
	// ================================================
	typedef logic [11:0] axil_addr_t;		// byte address on the host bus
	typedef logic [31:0] axil_data_t;		// one bus word

	localparam int TIME_WIDTH      = 16;	// delay and pulse fields, in clocks
	localparam int REP_WIDTH       = 12;	// repetition count
	localparam int HALT_CODE_WIDTH = 8;
	localparam int CMD_WIDTH       = 64;	// one entry = two bus words

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;	// unmapped address

	// ================================================
	// register map
	// ================================================
	localparam axil_addr_t REG_CTRL   = 12'h000;	// bit0 start, bit1 stop, reads 0
	localparam axil_addr_t REG_STATUS = 12'h004;	// busy, done, stopped, code in 15:8
	localparam axil_addr_t REG_PULSES = 12'h008;	// pulses since last start
	localparam axil_addr_t CMD_BASE   = 12'h100;	// entry i at base + 8*i, low word first

	// codes the sequencer makes up on its own
	localparam logic [HALT_CODE_WIDTH-1:0] CODE_BAD_OP  = 8'hEE;	// unknown opcode
	localparam logic [HALT_CODE_WIDTH-1:0] CODE_RUN_OFF = 8'hFF;	// ran past last entry

	// ================================================
	// command word
	// ================================================
	typedef enum logic [3:0] {
		OP_PULSE = 4'd1,
		OP_HALT  = 4'd2
	} cmd_op_e;

	typedef struct packed {
		logic [REP_WIDTH-1:0]  reps;	// times the pattern is played
		logic [TIME_WIDTH-1:0] idly;	// low before the pulse
		logic [TIME_WIDTH-1:0] pls;		// high time
		logic [TIME_WIDTH-1:0] edly;	// low after the pulse
	} pulse_cmd_t;

	typedef struct packed {
		logic [51:0]                reserved;
		logic [HALT_CODE_WIDTH-1:0] code;	// handed to the host
	} halt_cmd_t;

	// same 60 bits, read as pulse or halt depending on op
	typedef union packed {
		pulse_cmd_t pulse;
		halt_cmd_t  halt;
	} cmd_body_u;

	typedef struct packed {
		cmd_op_e   op;		// top nibble of the high word
		cmd_body_u body;
	} cmd_word_t;

	// ================================================
	// sequencer control and status
	// ================================================
	typedef struct packed {
		logic start;	// one cycle strobe
		logic stop;		// one cycle strobe
	} seq_ctrl_t;

	typedef struct packed {
		logic                       busy;
		logic                       done;
		logic                       stopped;
		logic [HALT_CODE_WIDTH-1:0] halt_code;
		logic                       pulse_stb;	// first high cycle of a pulse
	} seq_stat_t;

endpackage

//--- source/nmr_axil_regs.sv
`timescale 1ns/1ps
// axi4-lite slave of the sequencer with control, status, pulse counter
// and the write path into command memory
module nmr_axil_regs #(
	parameter  int CMD_DEPTH = 16,
	localparam int IDX_W     = $clog2(CMD_DEPTH)
) (
	input  logic                clock_50,
	input  logic                arst_n,
	// write address and data
	input  nmr_pkg::axil_addr_t s_axil_awaddr,
	input  logic                s_axil_awvalid,
	output logic                s_axil_awready,
	input  nmr_pkg::axil_data_t s_axil_wdata,
	input  logic                s_axil_wvalid,
	output logic                s_axil_wready,
	output logic [1:0]          s_axil_bresp,
	output logic                s_axil_bvalid,
	input  logic                s_axil_bready,
	// read address and data
	input  nmr_pkg::axil_addr_t s_axil_araddr,
	input  logic                s_axil_arvalid,
	output logic                s_axil_arready,
	output nmr_pkg::axil_data_t s_axil_rdata,
	output logic [1:0]          s_axil_rresp,
	output logic                s_axil_rvalid,
	input  logic                s_axil_rready,
	// sequencer side
	output nmr_pkg::seq_ctrl_t  ctrl,
	input  nmr_pkg::seq_stat_t  stat,
	output logic                wr_en,
	output logic [IDX_W-1:0]    wr_addr,
	output nmr_pkg::axil_data_t wr_data,
	output logic                wr_hi
);
	import nmr_pkg::*;

	localparam axil_addr_t CMD_LIMIT = axil_addr_t'(CMD_BASE + 8 * CMD_DEPTH);	// first addr past memory

	logic       wr_fire;	// write handshake this cycle
	logic       rd_fire;	// read handshake this cycle
	logic       aw_cmd;
	axil_data_t rd_word;	// read mux out
	logic       rd_ok;
	axil_data_t pulse_cnt;
	axil_data_t echo_lo;	// last command halves written
	axil_data_t echo_hi;

	// word aligned and inside the command window
	function automatic logic in_cmd(input axil_addr_t a);
		return (a >= CMD_BASE) && (a < CMD_LIMIT) && (a[1:0] == 2'b00);
	endfunction

	function automatic logic is_reg(input axil_addr_t a);
		return (a == REG_CTRL) || (a == REG_STATUS) || (a == REG_PULSES);
	endfunction

	// ================================================
	// write channel
	// ================================================
	assign wr_fire       = s_axil_awready && s_axil_awvalid && s_axil_wvalid;
	assign aw_cmd        = in_cmd(s_axil_awaddr);
	assign s_axil_wready = s_axil_awready;	// addr and data taken together

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			s_axil_awready <= 1'b0;
			s_axil_bvalid  <= 1'b0;
			s_axil_bresp   <= RESP_OKAY;
			ctrl           <= '0;
		end else begin
			s_axil_awready <= s_axil_awvalid && s_axil_wvalid
				&& !s_axil_awready && !s_axil_bvalid;	// one cycle, none pending
			ctrl <= '0;		// strobes self clear
			if (wr_fire) begin
				s_axil_bvalid <= 1'b1;
				s_axil_bresp  <= (aw_cmd || is_reg(s_axil_awaddr)) ? RESP_OKAY : RESP_SLVERR;
				if (s_axil_awaddr == REG_CTRL) begin
					ctrl.start <= s_axil_wdata[0];
					ctrl.stop  <= s_axil_wdata[1];
				end
			end else if (s_axil_bready) begin
				s_axil_bvalid <= 1'b0;	// held until taken
			end
		end
	end

	// command memory port, one half per bus word
	assign wr_en   = wr_fire && aw_cmd;
	assign wr_addr = s_axil_awaddr[IDX_W+2:3];	// 8 bytes per entry
	assign wr_hi   = s_axil_awaddr[2];
	assign wr_data = s_axil_wdata;

	// readback copy of the most recent entry
	always_ff @(posedge clock_50) begin
		if (wr_en && wr_hi) begin
			echo_hi <= s_axil_wdata;
		end
		if (wr_en && !wr_hi) begin
			echo_lo <= s_axil_wdata;
		end
	end

	// ================================================
	// pulse counter
	// ================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			pulse_cnt <= '0;
		end else if (ctrl.start && !ctrl.stop && !stat.busy) begin
			pulse_cnt <= '0;	// start that the fsm will take
		end else if (stat.pulse_stb) begin
			pulse_cnt <= pulse_cnt + 1'b1;
		end
	end

	// ================================================
	// read channel
	// ================================================
	assign rd_fire = s_axil_arready && s_axil_arvalid;

	always_comb begin
		rd_word = '0;
		rd_ok   = 1'b1;
		if (s_axil_araddr == REG_STATUS) begin
			rd_word = {16'd0, stat.halt_code, 5'd0, stat.stopped, stat.done, stat.busy};
		end else if (s_axil_araddr == REG_PULSES) begin
			rd_word = pulse_cnt;
		end else if (in_cmd(s_axil_araddr)) begin
			rd_word = s_axil_araddr[2] ? echo_hi : echo_lo;
		end else if (s_axil_araddr != REG_CTRL) begin
			rd_ok = 1'b0;	// outside the map
		end
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			s_axil_arready <= 1'b0;
			s_axil_rvalid  <= 1'b0;
			s_axil_rresp   <= RESP_OKAY;
		end else begin
			s_axil_arready <= s_axil_arvalid && !s_axil_arready && !s_axil_rvalid;
			if (rd_fire) begin
				s_axil_rvalid <= 1'b1;
				s_axil_rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
			end else if (s_axil_rready) begin
				s_axil_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock_50) begin
		if (rd_fire) begin
			s_axil_rdata <= rd_word;	// stable while rvalid waits
		end
	end

endmodule

//--- source/cmd_ram.sv
`timescale 1ns/1ps
// command memory, written in 32-bit halves from the bus side
// and read whole by the sequencer one cycle after rd_en
module cmd_ram #(
	parameter  int CMD_DEPTH = 16,
	localparam int IDX_W     = $clog2(CMD_DEPTH)
) (
	input  logic                clock_50,
	input  logic                wr_en,
	input  logic [IDX_W-1:0]    wr_addr,
	input  nmr_pkg::axil_data_t wr_data,
	input  logic                wr_hi,		// 1 = upper word
	input  logic                rd_en,
	input  logic [IDX_W-1:0]    rd_addr,
	output nmr_pkg::cmd_word_t  rd_data
);
	import nmr_pkg::*;

	localparam int HALF = CMD_WIDTH / 2;

	logic [CMD_WIDTH-1:0] mem [CMD_DEPTH];	// maps onto block ram

	always_ff @(posedge clock_50) begin
		if (wr_en) begin
			if (wr_hi) begin
				mem[wr_addr][CMD_WIDTH-1:HALF] <= wr_data;	// op, reps, idly
			end else begin
				mem[wr_addr][HALF-1:0] <= wr_data;			// pls, edly or code
			end
		end
		if (rd_en) begin
			rd_data <= cmd_word_t'(mem[rd_addr]);	// old data on collision
		end
	end

endmodule

//--- source/seq_timer.sv
`timescale 1ns/1ps
// phase timer of the sequencer
// after a load of N the expired flag marks the N-th cycle, i.e. the last one of the phase
module seq_timer (
	input  logic                           clock_50,
	input  logic                           arst_n,
	input  logic                           load,
	input  logic [nmr_pkg::TIME_WIDTH-1:0] load_value,	// never 0
	output logic                           expired
);
	import nmr_pkg::*;

	logic [TIME_WIDTH-1:0] count;	// cycles left in phase

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (load) begin
			count <= load_value;
		end else if (count != '0) begin
			count <= count - 1'b1;	// parks at zero
		end
	end

	// count is N in the first cycle of the phase
	assign expired = (count == TIME_WIDTH'(1));

endmodule

//--- source/seq_fsm.sv
`timescale 1ns/1ps
// sequencer state machine, walks command memory from entry 0
// and plays idly / pls / edly on pulse_out for every repetition
module seq_fsm #(
	parameter  int CMD_DEPTH = 16,
	localparam int IDX_W     = $clog2(CMD_DEPTH)
) (
	input  logic                           clock_50,
	input  logic                           arst_n,
	input  nmr_pkg::seq_ctrl_t             ctrl,
	input  nmr_pkg::cmd_word_t             rd_data,
	input  logic                           expired,
	output nmr_pkg::seq_stat_t             stat,
	output logic                           rd_en,
	output logic [IDX_W-1:0]               rd_addr,
	output logic                           load,
	output logic [nmr_pkg::TIME_WIDTH-1:0] load_value,
	output logic                           pulse_out
);
	import nmr_pkg::*;

	typedef enum logic [2:0] {IDLE, FETCH, DECODE, IDLY, PLS, EDLY} state_e;

	state_e                     state;
	state_e                     nxt;
	logic [IDX_W-1:0]           idx;		// entry being run
	logic [REP_WIDTH-1:0]       reps_left;	// includes current rep
	pulse_cmd_t                 cur;		// fields of running pulse cmd
	pulse_cmd_t                 src;
	logic [2:0]                 nz;			// {edly, pls, idly} non zero
	logic [2:0]                 avail;		// phases still ahead in this rep
	logic                       seek;		// pick next phase or entry
	logic                       more;
	logic                       wrap;
	logic                       adv;
	logic                       fin;
	logic                       stop_hit;
	logic [HALT_CODE_WIDTH-1:0] fin_code;
	logic                       done_q;
	logic                       stopped_q;
	logic                       stb_q;
	logic [HALT_CODE_WIDTH-1:0] code_q;

	// earliest phase in the mask, mask must not be empty
	function automatic state_e first_phase(input logic [2:0] m);
		if (m[0]) return IDLY;
		if (m[1]) return PLS;
		return EDLY;
	endfunction

	// fresh word in decode, latched copy afterwards
	assign src = (state == DECODE) ? rd_data.body.pulse : cur;
	assign nz  = {src.edly != '0, src.pls != '0, src.idly != '0};

	// ================================================
	// next state
	// ================================================
	always_comb begin
		nxt      = state;
		seek     = 1'b0;
		avail    = 3'b000;
		more     = 1'b0;
		wrap     = 1'b0;
		adv      = 1'b0;
		fin      = 1'b0;
		fin_code = CODE_RUN_OFF;
		load     = 1'b0;
		case (state)
			IDLE:   if (ctrl.start && !ctrl.stop) nxt = FETCH;
			FETCH:  nxt = DECODE;	// ram read in flight
			DECODE: begin
				case (rd_data.op)
					OP_PULSE: begin
						seek  = 1'b1;
						avail = (rd_data.body.pulse.reps != '0) ? nz : 3'b000;	// reps 0 skips
					end
					OP_HALT: begin
						nxt      = IDLE;
						fin      = 1'b1;
						fin_code = rd_data.body.halt.code;
					end
					default: begin
						nxt      = IDLE;	// unknown op acts as halt
						fin      = 1'b1;
						fin_code = CODE_BAD_OP;
					end
				endcase
			end
			IDLY, PLS, EDLY: begin
				if (expired) begin
					seek  = 1'b1;
					avail = (state == IDLY) ? (nz & 3'b110) :
						(state == PLS) ? (nz & 3'b100) : 3'b000;
					more  = reps_left > REP_WIDTH'(1);
				end
			end
			default: nxt = IDLE;
		endcase

		if (seek) begin
			if (avail != 3'b000) begin
				nxt  = first_phase(avail);	// next phase, same rep
				load = 1'b1;
			end else if (more) begin
				nxt  = first_phase(nz);		// next rep, no gap
				load = 1'b1;
				wrap = 1'b1;
			end else if (idx == IDX_W'(CMD_DEPTH - 1)) begin
				nxt = IDLE;		// past last entry
				fin = 1'b1;
			end else begin
				nxt = FETCH;
				adv = 1'b1;
			end
		end

		stop_hit = ctrl.stop && (state != IDLE);
		if (stop_hit) begin
			nxt  = IDLE;	// stop beats everything
			load = 1'b0;
			wrap = 1'b0;
			adv  = 1'b0;
			fin  = 1'b0;
		end
	end

	assign load_value = (nxt == IDLY) ? src.idly : (nxt == PLS) ? src.pls : src.edly;

	// ================================================
	// state and status registers
	// ================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			idx       <= '0;
			reps_left <= '0;
			done_q    <= 1'b0;
			stopped_q <= 1'b0;
			stb_q     <= 1'b0;
			code_q    <= '0;
		end else begin
			state <= nxt;
			stb_q <= load && (nxt == PLS);	// high in first PLS cycle
			if ((state == IDLE) && (nxt == FETCH)) begin
				idx       <= '0;	// new run
				done_q    <= 1'b0;
				stopped_q <= 1'b0;
				code_q    <= '0;
			end
			if (adv) idx <= idx + 1'b1;
			if (state == DECODE) begin
				reps_left <= rd_data.body.pulse.reps;
			end else if (wrap) begin
				reps_left <= reps_left - 1'b1;
			end
			if (fin) begin
				done_q <= 1'b1;
				code_q <= fin_code;
			end
			if (stop_hit) stopped_q <= 1'b1;
		end
	end

	always_ff @(posedge clock_50) begin
		if (state == DECODE) cur <= rd_data.body.pulse;
	end

	assign rd_en     = (state == FETCH);
	assign rd_addr   = idx;
	assign pulse_out = (state == PLS);
	assign stat      = '{busy: state != IDLE, done: done_q, stopped: stopped_q,
		halt_code: code_q, pulse_stb: stb_q};

endmodule

//--- source/nmr_seq_top.sv
`timescale 1ns/1ps
// top of the nmr pulse sequencer, host bus in and one pulse pin out
// CMD_DEPTH sets the command memory size for all blocks
module nmr_seq_top #(
	parameter int CMD_DEPTH = 16
) (
	input  logic                clock_50,
	input  logic                arst_n,
	input  nmr_pkg::axil_addr_t s_axil_awaddr,
	input  logic                s_axil_awvalid,
	output logic                s_axil_awready,
	input  nmr_pkg::axil_data_t s_axil_wdata,
	input  logic                s_axil_wvalid,
	output logic                s_axil_wready,
	output logic [1:0]          s_axil_bresp,
	output logic                s_axil_bvalid,
	input  logic                s_axil_bready,
	input  nmr_pkg::axil_addr_t s_axil_araddr,
	input  logic                s_axil_arvalid,
	output logic                s_axil_arready,
	output nmr_pkg::axil_data_t s_axil_rdata,
	output logic [1:0]          s_axil_rresp,
	output logic                s_axil_rvalid,
	input  logic                s_axil_rready,
	output logic                pulse_out
);
	import nmr_pkg::*;

	localparam int IDX_W = $clog2(CMD_DEPTH);

	seq_ctrl_t             ctrl;		// start / stop strobes
	seq_stat_t             stat;
	logic                  wr_en;
	logic [IDX_W-1:0]      wr_addr;
	axil_data_t            wr_data;
	logic                  wr_hi;
	logic                  rd_en;
	logic [IDX_W-1:0]      rd_addr;
	cmd_word_t             rd_data;
	logic                  load;		// timer reload
	logic [TIME_WIDTH-1:0] load_value;
	logic                  expired;

	nmr_axil_regs #(.CMD_DEPTH(CMD_DEPTH)) u_regs (
		.clock_50, .arst_n,
		.s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
		.s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
		.s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
		.s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
		.s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
		.ctrl, .stat, .wr_en, .wr_addr, .wr_data, .wr_hi
	);

	cmd_ram #(.CMD_DEPTH(CMD_DEPTH)) u_ram (
		.clock_50, .wr_en, .wr_addr, .wr_data, .wr_hi, .rd_en, .rd_addr, .rd_data
	);

	seq_fsm #(.CMD_DEPTH(CMD_DEPTH)) u_fsm (
		.clock_50, .arst_n, .ctrl, .rd_data, .expired,
		.stat, .rd_en, .rd_addr, .load, .load_value, .pulse_out
	);

	seq_timer u_timer (
		.clock_50, .arst_n, .load, .load_value, .expired
	);

endmodule

//--- verification/nmr_seq_properties.sv
`timescale 1ns/1ps
// bus and pin rules of the sequencer bound into the top level
module nmr_seq_properties (
	input logic        clock_50,
	input logic        arst_n,
	input logic        pulse_out,
	input logic        busy,
	input logic        done,
	input logic        stopped,
	input logic        s_axil_bvalid,
	input logic        s_axil_bready,
	input logic [1:0]  s_axil_bresp,
	input logic        s_axil_rvalid,
	input logic        s_axil_rready,
	input logic [31:0] s_axil_rdata,
	input logic [1:0]  s_axil_rresp
);
	int fail_count = 0;	// failed rules so far

	// pin only moves inside a run that has not ended
	pin_needs_run: assert property (@(posedge clock_50) disable iff (!arst_n)
		pulse_out |-> busy && !done && !stopped)
		else begin
			fail_count++;
			$error("pulse_out is high outside a running sequence");
		end

	// write response parked until the host takes it
	bvalid_holds: assert property (@(posedge clock_50) disable iff (!arst_n)
		s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
		else begin
			fail_count++;
			$error("write response dropped or changed before bready");
		end

	// read response frozen with its data and code
	rvalid_holds: assert property (@(posedge clock_50) disable iff (!arst_n)
		s_axil_rvalid && !s_axil_rready
		|=> s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp))
		else begin
			fail_count++;
			$error("read response dropped or changed before rready");
		end
endmodule

bind nmr_seq_top nmr_seq_properties u_props (
	.clock_50,
	.arst_n,
	.pulse_out,
	.busy(stat.busy),	// fsm status inside the top
	.done(stat.done),
	.stopped(stat.stopped),
	.s_axil_bvalid,
	.s_axil_bready,
	.s_axil_bresp,
	.s_axil_rvalid,
	.s_axil_rready,
	.s_axil_rdata,
	.s_axil_rresp
);

//--- verification/tb_clkgen.sv
`timescale 1ns/1ps
// clock and reset source of the sequencer testbench
// 8 ns clock, reset released a little after the 4th rising edge
module tb_clkgen #(
	parameter int HALF_PERIOD  = 4,	// ns
	parameter int RESET_CYCLES = 4
) (
	output logic clock_50,
	output logic arst_n
);
	initial begin
		clock_50 = 1'b0;
		forever #(HALF_PERIOD) clock_50 = ~clock_50;
	end

	initial begin
		arst_n = 1'b0;	// held from time 0
		repeat (RESET_CYCLES) @(posedge clock_50);
		#1 arst_n = 1'b1;
	end
endmodule

//--- verification/tb_nmr_seq.sv
`timescale 1ns/1ps
// directed tests of the nmr pulse sequencer through its axi4-lite port
// each test programs command memory, runs it and checks the pin and the registers
module tb_nmr_seq;
	import nmr_pkg::*;

	localparam int DEPTH      = 16;
	localparam int TIMEOUT    = 1000;	// cycles per wait loop
	localparam int POLL_LIMIT = 500;	// status reads per run

	logic       clock_50;
	logic       arst_n;
	axil_addr_t awaddr;
	logic       awvalid;
	logic       awready;
	axil_data_t wdata;
	logic       wvalid;
	logic       wready;
	logic [1:0] bresp;
	logic       bvalid;
	logic       bready;
	axil_addr_t araddr;
	logic       arvalid;
	logic       arready;
	axil_data_t rdata;
	logic [1:0] rresp;
	logic       rvalid;
	logic       rready;
	logic       pulse_out;

	int    err_count;
	string test_name;
	int    highs[$];	// lengths of high intervals
	int    gaps[$];		// low gaps between two highs
	int    run_len    = 0;
	logic  last_level = 1'b0;
	logic  seen_high  = 1'b0;

	tb_clkgen u_clk (.clock_50, .arst_n);

	nmr_seq_top #(.CMD_DEPTH(DEPTH)) uut (
		.clock_50, .arst_n,
		.s_axil_awaddr(awaddr), .s_axil_awvalid(awvalid), .s_axil_awready(awready),
		.s_axil_wdata(wdata), .s_axil_wvalid(wvalid), .s_axil_wready(wready),
		.s_axil_bresp(bresp), .s_axil_bvalid(bvalid), .s_axil_bready(bready),
		.s_axil_araddr(araddr), .s_axil_arvalid(arvalid), .s_axil_arready(arready),
		.s_axil_rdata(rdata), .s_axil_rresp(rresp), .s_axil_rvalid(rvalid),
		.s_axil_rready(rready), .pulse_out
	);

	// ================================================
	// pin monitor sampling once per cycle at the falling edge
	// ================================================
	always @(negedge clock_50) begin
		if (pulse_out !== last_level) begin
			if (last_level === 1'b1) highs.push_back(run_len);
			else if (seen_high) gaps.push_back(run_len);
			if (pulse_out) seen_high = 1'b1;
			run_len = 0;
		end
		run_len++;
		last_level = pulse_out;
	end

	task automatic clear_monitor();
		highs.delete();
		gaps.delete();
		seen_high = 1'b0;	// pin is low here
	endtask

	// ================================================
	// failure reporting and waiting
	// ================================================
	task automatic abort_run(input string msg);
		err_count++;
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic expect_equal(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			abort_run($sformatf("[ERROR] %s: %s expected 0x%0h actual 0x%0h",
				test_name, what, exp, act));
		end
	endtask

	// one clock step ending 1 ns after the edge where inputs change
	task automatic step_wait(inout int n, input string what);
		@(posedge clock_50);
		#1;
		n++;
		if (n > TIMEOUT) begin
			abort_run($sformatf("%s: no %s from the DUT within %0d cycles",
				test_name, what, TIMEOUT));
		end
	endtask

	// bound checker rules
	always @(posedge clock_50) begin
		assert (uut.u_props.fail_count == 0) else begin
			abort_run($sformatf("%s: a bus or pin rule of the bound checker failed",
				test_name));
		end
	end

	// ================================================
	// axi4-lite host
	// ================================================
	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
			input int hold, output logic [1:0] resp);
		int n;
		int i;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = (hold == 0);	// low means back-pressure
		n = 0;
		while (!awready) step_wait(n, "awready");
		expect_equal("wready with awready", 1, wready);
		step_wait(n, "write handshake");	// accepted at this edge
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		while (!bvalid) step_wait(n, "bvalid");
		resp = bresp;
		for (i = 0; i < hold; i++) begin
			step_wait(n, "stalled write response");
			expect_equal("bvalid while bready low", 1, bvalid);
			expect_equal("bresp while bready low", resp, bresp);
		end
		bready = 1'b1;
		n = 0;
		while (bvalid) step_wait(n, "bvalid release");
	endtask

	task automatic axil_read(input axil_addr_t addr, input int hold,
			output axil_data_t data, output logic [1:0] resp);
		int n;
		int i;
		araddr  = addr;
		arvalid = 1'b1;
		rready  = (hold == 0);
		n = 0;
		while (!arready) step_wait(n, "arready");
		step_wait(n, "read handshake");
		arvalid = 1'b0;
		n = 0;
		while (!rvalid) step_wait(n, "rvalid");
		data = rdata;
		resp = rresp;
		for (i = 0; i < hold; i++) begin
			step_wait(n, "stalled read response");
			expect_equal("rvalid while rready low", 1, rvalid);
			expect_equal("rdata while rready low", data, rdata);
			expect_equal("rresp while rready low", resp, rresp);
		end
		rready = 1'b1;
		n = 0;
		while (rvalid) step_wait(n, "rvalid release");
	endtask

	task automatic write_ok(input axil_addr_t addr, input axil_data_t data);
		logic [1:0] r;
		axil_write(addr, data, 0, r);
		expect_equal($sformatf("bresp at 0x%0h", addr), 2'b00, r);
	endtask

	task automatic read_ok(input axil_addr_t addr, output axil_data_t data);
		logic [1:0] r;
		axil_read(addr, 0, data, r);
		expect_equal($sformatf("rresp at 0x%0h", addr), 2'b00, r);
	endtask

	// ================================================
	// command words and run control
	// ================================================
	// op on top followed by reps, idly, pls and edly
	function automatic logic [63:0] pulse_word(input int reps, input int idly,
			input int pls, input int edly);
		return {4'd1, 12'(reps), 16'(idly), 16'(pls), 16'(edly)};
	endfunction

	function automatic logic [63:0] halt_word(input logic [7:0] code);
		return {4'd2, 52'd0, code};
	endfunction

	// status word of an idle sequencer
	function automatic logic [31:0] expected_status(input logic done, input logic stopped,
			input logic [7:0] code);
		logic [31:0] v;
		v = 32'(code) << 8;	// halt code in 15:8
		if (done) v = v | 32'h2;
		if (stopped) v = v | 32'h4;
		return v;
	endfunction

	task automatic write_cmd(input int idx, input logic [63:0] word);
		write_ok(axil_addr_t'(12'h100 + 8 * idx), word[31:0]);		// low word first
		write_ok(axil_addr_t'(12'h100 + 8 * idx + 4), word[63:32]);
	endtask

	task automatic wait_idle(output axil_data_t stat_word);
		int n;
		n = 0;
		read_ok(REG_STATUS, stat_word);
		while (stat_word[0]) begin
			n++;
			if (n > POLL_LIMIT) begin
				abort_run($sformatf("%s: sequencer never went idle", test_name));
			end
			read_ok(REG_STATUS, stat_word);
		end
	endtask

	task automatic run_program(output axil_data_t stat_word);
		clear_monitor();
		write_ok(REG_CTRL, 32'h1);	// start
		wait_idle(stat_word);
	endtask

	// ================================================
	// tests
	// ================================================
	task automatic test_reset_map();
		axil_data_t d;
		logic [1:0] r;
		logic [63:0] w;
		test_name = "reset_map";
		expect_equal("bus valid and ready outputs", 0,
			{awready, wready, bvalid, arready, rvalid});
		expect_equal("pulse_out after reset", 0, pulse_out);
		read_ok(REG_STATUS, d);
		expect_equal("STATUS after reset", 0, d);
		read_ok(REG_PULSES, d);
		expect_equal("PULSES after reset", 0, d);
		axil_read(12'h0F0, 0, d, r);
		expect_equal("rresp of unmapped read", 2'b10, r);
		axil_write(12'h0F0, 32'hDEAD_BEEF, 0, r);
		expect_equal("bresp of unmapped write", 2'b10, r);
		w = {$urandom, $urandom};
		write_cmd(5, w);
		read_ok(12'h128, d);
		expect_equal("command low half", w[31:0], d);
		read_ok(12'h12C, d);
		expect_equal("command high half", w[63:32], d);
	endtask

	task automatic test_single_pulse();
		axil_data_t d;
		int idly;
		int pls;
		int edly;
		test_name = "single_pulse";
		idly = 1 + ($urandom % 20);
		pls  = 1 + ($urandom % 20);
		edly = 1 + ($urandom % 20);
		write_cmd(0, pulse_word(1, idly, pls, edly));
		write_cmd(1, halt_word(8'h5A));
		run_program(d);
		expect_equal("STATUS at end", expected_status(1, 0, 8'h5A), d);
		expect_equal("number of pulses", 1, highs.size());
		expect_equal("pulse width", pls, highs[0]);
		read_ok(REG_PULSES, d);
		expect_equal("PULSES", 1, d);
	endtask

	task automatic test_repetition();
		axil_data_t d;
		int idly;
		int pls;
		int edly;
		int i;
		test_name = "repetition";
		idly = 1 + ($urandom % 20);
		pls  = 1 + ($urandom % 20);
		edly = 1 + ($urandom % 20);
		write_cmd(0, pulse_word(3, idly, pls, edly));
		write_cmd(1, halt_word(8'hA5));
		run_program(d);
		expect_equal("STATUS at end", expected_status(1, 0, 8'hA5), d);
		expect_equal("number of pulses", 3, highs.size());
		expect_equal("number of gaps", 2, gaps.size());
		for (i = 0; i < 3; i++) begin
			expect_equal($sformatf("width of pulse %0d", i), pls, highs[i]);
		end
		for (i = 0; i < 2; i++) begin
			expect_equal($sformatf("gap %0d", i), edly + idly, gaps[i]);
		end
		read_ok(REG_PULSES, d);
		expect_equal("PULSES", 3, d);
	endtask

	task automatic test_skip_runoff();
		axil_data_t d;
		int i;
		test_name = "skip_runoff";
		write_cmd(0, pulse_word(2, 3, 0, 4));	// no high phase
		write_cmd(1, pulse_word(0, 5, 6, 7));	// no repetitions
		for (i = 2; i < DEPTH; i++) write_cmd(i, pulse_word(0, 7, 9, 11));
		run_program(d);
		expect_equal("STATUS at end", expected_status(1, 0, 8'hFF), d);
		expect_equal("number of pulses", 0, highs.size());
		read_ok(REG_PULSES, d);
		expect_equal("PULSES", 0, d);
	endtask

	task automatic test_stop();
		axil_data_t d;
		int n;
		test_name = "stop";
		write_cmd(0, pulse_word(4, 30, 40, 5));	// long train
		write_cmd(1, halt_word(8'h3C));
		clear_monitor();
		write_ok(REG_CTRL, 32'h1);
		n = 0;
		while (!pulse_out) step_wait(n, "first pulse");
		write_ok(REG_CTRL, 32'h2);	// stop inside the pulse
		n = 0;
		while (pulse_out) begin
			if (n == 2) abort_run("stop: pulse_out still high two cycles after the stop");
			step_wait(n, "pulse_out to fall");
		end
		read_ok(REG_STATUS, d);
		expect_equal("STATUS after stop", expected_status(0, 1, 8'h00), d);
		read_ok(REG_PULSES, d);
		expect_equal("PULSES after stop", 1, d);
		write_ok(REG_CTRL, 32'h1);	// restart
		read_ok(REG_PULSES, d);
		expect_equal("PULSES after restart", 0, d);
		wait_idle(d);
		expect_equal("STATUS after restart", expected_status(1, 0, 8'h3C), d);
		read_ok(REG_PULSES, d);
		expect_equal("PULSES at end", 4, d);
	endtask

	task automatic test_back_pressure();
		axil_data_t v;
		axil_data_t d;
		logic [1:0] r;
		test_name = "back_pressure";
		v = $urandom;
		axil_write(12'h110, v, 1 + ($urandom % 10), r);
		expect_equal("bresp of command write", 2'b00, r);
		axil_read(12'h110, 1 + ($urandom % 10), d, r);
		expect_equal("rresp of command read", 2'b00, r);
		expect_equal("command readback", v, d);
		axil_read(12'h0F0, 1 + ($urandom % 10), d, r);
		expect_equal("rresp of unmapped read", 2'b10, r);
		axil_write(12'h0FC, v, 1 + ($urandom % 10), r);
		expect_equal("bresp of unmapped write", 2'b10, r);
	endtask

	// ================================================
	// main sequence
	// ================================================
	initial begin
		int n;
		void'($urandom(32'h194e4bd1));
		err_count = 0;
		test_name = "reset";
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wvalid    = 1'b0;
		bready    = 1'b1;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b1;
		n = 0;
		while (arst_n !== 1'b1) step_wait(n, "reset release");
		step_wait(n, "first cycle after reset");
		test_reset_map();
		test_single_pulse();
		test_repetition();
		test_skip_runoff();
		test_stop();
		test_back_pressure();
		assert (uut.u_props.fail_count == 0) else begin
			err_count++;
			$display("%s: a bus or pin rule of the bound checker failed", test_name);
		end
		if (err_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end
endmodule

//--- vlog.f
source/nmr_pkg.sv
source/nmr_axil_regs.sv
source/cmd_ram.sv
source/seq_timer.sv
source/seq_fsm.sv
source/nmr_seq_top.sv
verification/nmr_seq_properties.sv
verification/tb_clkgen.sv
verification/tb_nmr_seq.sv
